// ==== src/audio_pkg.sv ====
// ##############################
// Widths, vector types and FSM state encodings shared by the audio datapath
// ##############################
package audio_pkg;

	typedef logic [24:0] mem_addr_t;	// Word address into sample memory
	typedef logic [15:0] mem_word_t;	// One memory word
	typedef logic [47:0] bit_queue_t;	// Unplayed bits, oldest on top
	typedef logic [13:0] g711_sample_t;	// Expanded G.711 sample, two's complement
	typedef logic [5:0] slot_count_t;	// Bit position inside an I2S slot

	localparam int SLOT_BITS = 32;	// Bits per I2S channel slot

	// Playback control, header parse then slot loop
	typedef enum logic [3:0] {
		check_riff,
		skip_header,
		read_format,
		skip_to_data,
		wait_left,
		left_slot,
		left_pad,
		right_slot,
		right_pad,
		halted
	} play_state_t;

	// Sample fetch, initial fill then prefetch or post-drop refill
	typedef enum logic [1:0] {
		fill,
		idle,
		request,
		wait_ack
	} fetch_state_t;

endpackage

// ==== src/g711_expander.sv ====
// ##############################
// G.711 A-law and mu-law byte expander; result registered on the expand strobe
// ##############################
`timescale 1ns/1ns

module g711_expander import audio_pkg::*; (
	input  logic clk50,
	input  logic reset,
	input  logic [7:0] code_byte,	// Compressed byte from the queue top
	input  logic alaw,	// 1 for A-law, 0 for mu-law
	input  logic expand,
	output g711_sample_t g711_sample
);

	logic [7:0] a_byte, u_byte;
	logic [12:0] a_mag, u_mag, mag;
	logic negative;
	g711_sample_t linear;

	assign a_byte = code_byte ^ 8'h55;	// A-law stores even bits inverted
	assign u_byte = ~code_byte;	// mu-law stores every bit inverted

	// A-law magnitude at twice the 13-bit scale
	always_comb begin
		if (a_byte[6:4] == 3'd0)
			a_mag = 13'({a_byte[3:0], 2'b10});	// Linear segment
		else
			a_mag = 13'({1'b1, a_byte[3:0], 2'b10}) << (a_byte[6:4] - 3'd1);
	end

	// (mantissa*2 + 33) << segment, then bias removed
	assign u_mag = (13'({1'b1, u_byte[3:0], 1'b1}) << u_byte[6:4]) - 13'd33;

	assign mag = alaw ? a_mag : u_mag;
	assign negative = alaw ? ~a_byte[7] : u_byte[7];	// Opposite sign conventions
	assign linear = negative ? (14'd0 - {1'b0, mag}) : {1'b0, mag};

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset)
			g711_sample <= '0;
		else if (expand)
			g711_sample <= linear;	// Held for the whole slot
	end

endmodule

// ==== src/i2s_clock_sync.sv ====
// ##############################
// Brings the codec bit and frame clocks into clk50 and flags their edges
// ##############################
`timescale 1ns/1ns

module i2s_clock_sync #(
	parameter int SYNC_STAGES = 2	// Flops per synchronizer chain
) (
	input  logic clk50,
	input  logic reset,
	input  logic i2s_sclk,
	input  logic i2s_lrclk,
	output logic sclk_rise,
	output logic sclk_fall,
	output logic lrclk_rise,
	output logic lrclk_fall
);

	logic [SYNC_STAGES-1:0][1:0] sync_chain;	// Bit 1 frame clock, bit 0 bit clock
	logic [1:0] synced;
	logic [1:0] edge_reg;	// Synced value one cycle back

	assign synced = sync_chain[SYNC_STAGES-1];

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			sync_chain <= '0;
			edge_reg <= '0;
		end
		else begin
			sync_chain[0] <= {i2s_lrclk, i2s_sclk};
			for (int i = 1; i < SYNC_STAGES; i++)
				sync_chain[i] <= sync_chain[i-1];
			edge_reg <= synced;
		end
	end

	assign sclk_rise = synced[0] & ~edge_reg[0];
	assign sclk_fall = ~synced[0] & edge_reg[0];
	assign lrclk_rise = synced[1] & ~edge_reg[1];	// Start of right channel
	assign lrclk_fall = ~synced[1] & edge_reg[1];	// Start of left channel

endmodule

// ==== src/playback_control.sv ====
// ##############################
// WAV header parser and I2S slot FSM; drives the codec data line from the queue
// ##############################
`timescale 1ns/1ns

module playback_control import audio_pkg::*, wav_format_pkg::*; #(
	parameter int VOLUME_SHIFT = 1	// Leading sign copies per slot
) (
	input  logic clk50,
	input  logic reset,
	input  logic i2s_enable,
	input  bit_queue_t bit_queue,
	input  logic queue_ready,
	input  logic sclk_rise,
	input  logic sclk_fall,
	input  logic lrclk_rise,
	input  logic lrclk_fall,
	input  g711_sample_t g711_sample,
	output logic shift_bits,
	output slot_count_t shift_count,
	output logic drop_word,
	output logic expand,
	output logic alaw,
	output logic i2s_din,
	output format_code_t format_code
);

	play_state_t state, state_n;
	slot_count_t slot_count, count_n;	// Position of the next bit in the slot
	logic [4:0] word_index;	// Index of the word on top of the queue
	logic g711_mode, g711_n, alaw_n;
	logic edge_seen, edge_n;	// Frame edge seen, slot starts on next bit clock rise
	logic din_bit, din_n;
	logic sign_bit, sign_n;	// PCM sign kept for the padding
	format_code_t format_n;
	slot_count_t data_pos, data_last;
	logic lead_sign, data_bit, pad_sign, frame_edge;

	assign data_pos = slot_count - slot_count_t'(VOLUME_SHIFT);
	assign data_last = slot_count_t'(VOLUME_SHIFT) + (g711_mode ? 6'd13 : 6'd15);
	assign lead_sign = g711_mode ? g711_sample[13] : bit_queue[47];
	assign data_bit = g711_mode ? g711_sample[4'd13 - data_pos[3:0]] : bit_queue[47];	// MSB first
	assign pad_sign = g711_mode ? g711_sample[13] : sign_bit;
	assign frame_edge = (state == left_pad) ? lrclk_rise : lrclk_fall;
	assign shift_count = g711_mode ? 6'd8 : 6'd1;	// Whole byte or one PCM bit
	assign i2s_din = i2s_enable & din_bit;

	always_comb begin
		state_n = state;
		count_n = slot_count;
		g711_n = g711_mode;
		alaw_n = alaw;
		edge_n = edge_seen;
		din_n = din_bit;
		sign_n = sign_bit;
		format_n = format_code;
		shift_bits = 1'b0;
		drop_word = 1'b0;
		expand = 1'b0;
		if (i2s_enable && queue_ready) begin	// No step while a word is missing
			case (state)
				check_riff: begin
					if (bit_queue[47:16] == RIFF_TAG) begin
						drop_word = 1'b1;
						state_n = skip_header;
					end
					else begin
						format_n = FMT_UNKNOWN;	// Not a WAV file
						state_n = halted;
					end
				end
				skip_header: begin
					if (word_index == 5'(FORMAT_WORD))
						state_n = read_format;
					else
						drop_word = 1'b1;
				end
				read_format: begin
					g711_n = (bit_queue[47:32] != TAG_PCM);
					alaw_n = (bit_queue[47:32] == TAG_ALAW);
					case (bit_queue[47:32])
						TAG_PCM, TAG_ALAW, TAG_MULAW: begin
							drop_word = 1'b1;
							state_n = skip_to_data;
						end
						default: begin
							format_n = FMT_UNKNOWN;
							state_n = halted;
						end
					endcase
				end
				skip_to_data: begin
					if (word_index == 5'(DATA_WORD)) begin
						// Header done, visible on the format output
						format_n = !g711_mode ? FMT_PCM : (alaw ? FMT_ALAW : FMT_MULAW);
						state_n = wait_left;
					end
					else
						drop_word = 1'b1;
				end
				left_slot, right_slot: begin
					if (sclk_fall) begin
						count_n = slot_count + 6'd1;
						if (slot_count < slot_count_t'(VOLUME_SHIFT)) begin
							din_n = lead_sign;	// Attenuation by sign copies
						end
						else begin
							din_n = data_bit;
							shift_bits = !g711_mode;
							if (data_pos == '0)
								sign_n = bit_queue[47];
						end
						if (slot_count == data_last || slot_count == slot_count_t'(SLOT_BITS - 1)) begin
							shift_bits = 1'b1;	// Last PCM bit or the spent G.711 byte
							state_n = (state == left_slot) ? left_pad : right_pad;
						end
					end
				end
				wait_left, left_pad, right_pad: begin
					if (sclk_fall && state != wait_left)
						din_n = pad_sign;	// Sign fill through bit 31
					// First rise after the frame edge is the I2S delay bit
					if (edge_seen && sclk_rise) begin
						state_n = (state == left_pad) ? right_slot : left_slot;
						count_n = '0;
						edge_n = 1'b0;
						expand = g711_mode;	// Result ready long before bit 0
					end
					else if (frame_edge) begin
						edge_n = 1'b1;
					end
				end
				default: ;	// halted, line stays low
			endcase
		end
	end

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			state <= check_riff;
			slot_count <= '0;
			word_index <= '0;
			g711_mode <= 1'b0;
			alaw <= 1'b0;
			edge_seen <= 1'b0;
			din_bit <= 1'b0;
			sign_bit <= 1'b0;
			format_code <= FMT_NONE;
		end
		else begin
			state <= state_n;
			slot_count <= count_n;
			g711_mode <= g711_n;
			alaw <= alaw_n;
			edge_seen <= edge_n;
			din_bit <= din_n;
			sign_bit <= sign_n;
			format_code <= format_n;
			if (drop_word)
				word_index <= word_index + 5'd1;	// Next word moves to the top
		end
	end

endmodule

// ==== src/sample_fetch.sv ====
// ##############################
// Sample memory reader; keeps a 48-bit bit queue topped up one word at a time
// ##############################
`timescale 1ns/1ns

module sample_fetch import audio_pkg::*; (
	input  logic clk50,
	input  logic reset,
	input  logic i2s_enable,
	input  logic shift_bits,	// Consume shift_count bits from the top
	input  slot_count_t shift_count,
	input  logic drop_word,	// Discard the top word at once
	output mem_addr_t mem_addr,
	output logic mem_read,
	input  mem_word_t mem_data,
	input  logic mem_ack,
	output bit_queue_t bit_queue,
	output logic queue_ready
);

	fetch_state_t state, state_n;
	logic [5:0] empty_bits, empty_n;	// Unfilled bits at the bottom of the queue
	bit_queue_t queue_n;
	logic landed;

	// A word arrives on the ack of an open read
	assign landed = mem_read & mem_ack;

	// Prefetch keeps the queue usable, a drop refill does not
	assign queue_ready = (state == idle) || (state == request);

	always_comb begin
		queue_n = bit_queue;
		empty_n = empty_bits;
		state_n = state;

		// New word goes just below the valid bits
		if (landed) begin
			queue_n = queue_n | (bit_queue_t'(mem_data) << (empty_bits - 6'd16));
			empty_n = empty_n - 6'd16;
		end
		if (shift_bits) begin
			queue_n = queue_n << shift_count;	// Zeros fill in from the bottom
			empty_n = empty_n + shift_count;
		end
		if (drop_word) begin
			queue_n = queue_n << 16;
			empty_n = empty_n + 6'd16;
		end

		// Whole word free at the bottom means a read is due
		if (empty_n < 6'd16)
			state_n = idle;
		else if (drop_word)
			state_n = wait_ack;	// Top word gone, hold the player until refilled
		else if (state == idle)
			state_n = request;	// Prefetch while the queue keeps playing
	end

	always_ff @(posedge clk50 or posedge reset) begin
		if (reset) begin
			state <= fill;
			empty_bits <= 6'd48;	// Three words to load after reset
			bit_queue <= '0;	// Landing ORs into zeros
			mem_addr <= '0;
			mem_read <= 1'b0;
		end
		else begin
			state <= state_n;
			empty_bits <= empty_n;
			bit_queue <= queue_n;
			// Read held until ack, then low for one cycle at least
			if (landed) begin
				mem_addr <= mem_addr + 25'd1;
				mem_read <= 1'b0;
			end
			else if (state != idle && !mem_read && i2s_enable) begin
				mem_read <= 1'b1;	// Address already stable here
			end
		end
	end

endmodule

// ==== src/wav_format_pkg.sv ====
// ##############################
// WAV header layout, format tags and display codes for the format output
// ##############################
package wav_format_pkg;

	typedef logic [3:0] format_code_t;	// Code shown on the format display

	localparam format_code_t FMT_NONE = 4'h0;	// Header not parsed yet
	localparam format_code_t FMT_PCM = 4'h1;
	localparam format_code_t FMT_MULAW = 4'h2;
	localparam format_code_t FMT_ALAW = 4'hA;
	localparam format_code_t FMT_UNKNOWN = 4'hF;	// Not RIFF or unsupported tag

	// Format tags as read from the format word
	localparam logic [15:0] TAG_PCM = 16'h0001;
	localparam logic [15:0] TAG_ALAW = 16'h0006;
	localparam logic [15:0] TAG_MULAW = 16'h0007;

	// "RIFF" as two little-endian memory words
	localparam logic [31:0] RIFF_TAG = 32'h4952_4646;

	// Word indices into the file image
	localparam int FORMAT_WORD = 10;	// Byte offset 20
	localparam int DATA_WORD = 22;	// Byte offset 44, first sample

endpackage

// ==== src/wav_player.sv ====
// ##############################
// WAV player top level; reads a WAV image from memory and feeds an I2S codec
// ##############################
`timescale 1ns/1ns

module wav_player import audio_pkg::*, wav_format_pkg::*; #(
	parameter int VOLUME_SHIFT = 1,	// Output attenuation in bits
	parameter int SYNC_STAGES = 2	// Synchronizer depth for the codec clocks
) (
	input  logic clk50,
	input  logic reset,
	input  logic i2s_enable,
	output mem_addr_t mem_addr,
	output logic mem_read,
	input  mem_word_t mem_data,
	input  logic mem_ack,
	input  logic i2s_sclk,
	input  logic i2s_lrclk,
	output logic i2s_din,
	output format_code_t format_code
);

	bit_queue_t bit_queue;	// Queue contents, top byte also feeds the expander
	logic queue_ready;
	logic shift_bits;
	slot_count_t shift_count;
	logic drop_word;
	logic sclk_rise, sclk_fall;
	logic lrclk_rise, lrclk_fall;
	logic expand, alaw;
	g711_sample_t g711_sample;

	sample_fetch u_fetch (
		.clk50(clk50),
		.reset(reset),
		.i2s_enable(i2s_enable),
		.shift_bits(shift_bits),
		.shift_count(shift_count),
		.drop_word(drop_word),
		.mem_addr(mem_addr),
		.mem_read(mem_read),
		.mem_data(mem_data),
		.mem_ack(mem_ack),
		.bit_queue(bit_queue),
		.queue_ready(queue_ready)
	);

	i2s_clock_sync #(.SYNC_STAGES(SYNC_STAGES)) u_sync (
		.clk50(clk50),
		.reset(reset),
		.i2s_sclk(i2s_sclk),
		.i2s_lrclk(i2s_lrclk),
		.sclk_rise(sclk_rise),
		.sclk_fall(sclk_fall),
		.lrclk_rise(lrclk_rise),
		.lrclk_fall(lrclk_fall)
	);

	playback_control #(.VOLUME_SHIFT(VOLUME_SHIFT)) u_control (
		.clk50(clk50),
		.reset(reset),
		.i2s_enable(i2s_enable),
		.bit_queue(bit_queue),
		.queue_ready(queue_ready),
		.sclk_rise(sclk_rise),
		.sclk_fall(sclk_fall),
		.lrclk_rise(lrclk_rise),
		.lrclk_fall(lrclk_fall),
		.g711_sample(g711_sample),
		.shift_bits(shift_bits),
		.shift_count(shift_count),
		.drop_word(drop_word),
		.expand(expand),
		.alaw(alaw),
		.i2s_din(i2s_din),
		.format_code(format_code)
	);

	g711_expander u_expander (
		.clk50(clk50),
		.reset(reset),
		.code_byte(bit_queue[47:40]),	// Oldest byte in the queue
		.alaw(alaw),
		.expand(expand),
		.g711_sample(g711_sample)
	);

endmodule

// ==== testbench/wav_memory_model.sv ====
// ##############################
// Testbench word memory for the player
// Each read is acked after a pseudo-random 1 to 4 cycle delay
// ##############################
`timescale 1ns/1ns

module wav_memory_model import audio_pkg::*; #(
	parameter int DEPTH = 64	// Words held, higher addresses read the fill pattern
) (
	input  logic clk50,
	input  logic reset,
	input  mem_addr_t mem_addr,
	input  logic mem_read,
	output mem_word_t mem_data,
	output logic mem_ack
);

	mem_word_t words [0:DEPTH-1];	// WAV image, loaded by the testbench
	logic [31:0] lfsr;
	logic busy;	// Read seen, ack still to come
	int wait_cycles;

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return (state >> 1) ^ (state[0] ? 32'h8020_0003 : 32'h0);
	endfunction

	// Every address bit feeds the pattern
	function automatic mem_word_t fill_word(input mem_addr_t addr);
		return addr[15:0] ^ {7'h00, addr[24:16]} ^ 16'h5aa5;
	endfunction

	// Two LFSR bits, one step each, give the delay
	task automatic pick_delay();
		wait_cycles = 1;
		for (int i = 0; i < 2; i++) begin
			wait_cycles += int'(lfsr[0]) << i;
			lfsr = lfsr_step(lfsr);
		end
	endtask

	initial begin
		lfsr = 32'h609c4ae7;
		for (int i = 0; i < DEPTH; i++)
			words[i] = fill_word(mem_addr_t'(i));
		mem_data = '0;
		mem_ack = 1'b0;
		busy = 1'b0;
		wait_cycles = 0;
	end

	// Driven on the falling edge, DUT samples on the rising one
	always @(negedge clk50 or posedge reset) begin
		mem_ack = 1'b0;	// Single cycle pulse
		if (reset) begin
			busy = 1'b0;
		end
		else if (mem_read) begin
			if (!busy) begin
				busy = 1'b1;	// New request
				pick_delay();
			end
			wait_cycles--;
			if (wait_cycles == 0) begin
				mem_data = (mem_addr < DEPTH) ? words[mem_addr] : fill_word(mem_addr);
				mem_ack = 1'b1;
				busy = 1'b0;
			end
		end
	end

endmodule

// ==== testbench/wav_player_tb.sv ====
// ##############################
// WAV player testbench; plays a table of WAV images through
// an I2S master model and decodes every slot
// ##############################
`timescale 1ns/1ns

module wav_player_tb import audio_pkg::*, wav_format_pkg::*; ();

	localparam int VOLUME_SHIFT = 1;
	localparam int ROWS = 6;
	localparam int ROW_FRAMES = 10;	// Frames per row covering header, pause and playback with margin
	localparam int FRAME_CYCLES = 64 * 16;	// 64 bit clocks of 16 clk50 cycles
	localparam int CYCLE_LIMIT = ROWS * ROW_FRAMES * FRAME_CYCLES;

	typedef struct packed {
		logic riff;	// Image starts with the RIFF tag
		logic pause;	// Drop i2s_enable for three frames mid-stream
		logic [15:0] tag;	// Format tag at word 10
		logic [95:0] samples;	// Six data words, first one on top
		format_code_t format;	// Expected display code
	} test_row_t;

	logic clk50, reset, i2s_enable;
	mem_addr_t mem_addr;
	logic mem_read, mem_ack;
	mem_word_t mem_data;
	logic i2s_sclk, i2s_lrclk, i2s_din;
	format_code_t format_code;
	test_row_t tests [ROWS];
	logic [31:0] expected [$];	// Slot words in play order
	int cycles = 0;
	int next_addr = 0;	// Address the next ack must carry
	int error_count = 0;

	wav_player #(.VOLUME_SHIFT(VOLUME_SHIFT), .SYNC_STAGES(2)) dut (
		.clk50(clk50),
		.reset(reset),
		.i2s_enable(i2s_enable),
		.mem_addr(mem_addr),
		.mem_read(mem_read),
		.mem_data(mem_data),
		.mem_ack(mem_ack),
		.i2s_sclk(i2s_sclk),
		.i2s_lrclk(i2s_lrclk),
		.i2s_din(i2s_din),
		.format_code(format_code)
	);

	wav_memory_model mem_model (
		.clk50(clk50),
		.reset(reset),
		.mem_addr(mem_addr),
		.mem_read(mem_read),
		.mem_data(mem_data),
		.mem_ack(mem_ack)
	);

	initial begin
		clk50 = 1'b0;
		forever #2 clk50 = ~clk50;
	end

	task automatic fail_run(input string reason);
		error_count++;
		$display("%s", reason);
		$display("test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want)
			fail_run($sformatf("MISMATCH %s: got %h, expected %h", name, got, want));
	endtask

	// Expected slot word with bit 0 in the MSB
	// Sign copies lead, the sample follows MSB first and the sign pads the rest
	function automatic logic [31:0] slot_word(input logic [15:0] sample, input int width);
		logic [31:0] word;
		for (int n = 0; n < 32; n++) begin
			if (n >= VOLUME_SHIFT && n < VOLUME_SHIFT + width)
				word[31 - n] = sample[width - 1 - (n - VOLUME_SHIFT)];
			else
				word[31 - n] = sample[width - 1];
		end
		return word;
	endfunction

	// Twice the 13-bit A-law value of a code with its even bits stored inverted
	function automatic logic [13:0] alaw_value(input logic [7:0] code);
		logic [7:0] flipped;
		int seg;
		int mag;
		flipped = code ^ 8'h55;
		seg = flipped[6:4];
		if (seg == 0)
			mag = 2 * (2 * flipped[3:0] + 1);
		else
			mag = 2 * ((2 * flipped[3:0] + 33) << (seg - 1));
		return flipped[7] ? 14'(mag) : 14'(-mag);	// Bit 7 set means positive
	endfunction

	function automatic logic [13:0] mulaw_value(input logic [7:0] code);
		logic [7:0] flipped;
		int mag;
		flipped = ~code;
		mag = ((2 * flipped[3:0] + 33) << flipped[6:4]) - 33;	// Bias removed
		return flipped[7] ? 14'(-mag) : 14'(mag);
	endfunction

	task automatic load_image(input test_row_t row);
		mem_model.words[0] = row.riff ? 16'h4952 : 16'h4f4d;	// "RI" or junk
		mem_model.words[1] = 16'h4646;	// "FF"
		for (int i = 2; i < DATA_WORD; i++)
			mem_model.words[i] = {8'(i), 8'(8'hc0 ^ i)};	// Other header fields
		mem_model.words[FORMAT_WORD] = row.tag;
		for (int i = 0; i < 6; i++)
			mem_model.words[DATA_WORD + i] = row.samples[95 - 16 * i -: 16];
	endtask

	task automatic build_expected(input test_row_t row);
		logic [15:0] word;
		logic [7:0] code;
		expected.delete();	// Halted rows expect no slots
		for (int i = 0; i < 12; i++) begin
			word = row.samples[95 - 16 * (i / 2) -: 16];
			code = i[0] ? word[7:0] : word[15:8];	// High byte plays first
			if (row.format == FMT_ALAW)
				expected.push_back(slot_word({2'b00, alaw_value(code)}, 14));
			else if (row.format == FMT_MULAW)
				expected.push_back(slot_word({2'b00, mulaw_value(code)}, 14));
			else if (row.format == FMT_PCM && i < 6)
				expected.push_back(slot_word(row.samples[95 - 16 * i -: 16], 16));
		end
	endtask

	// Codec master model with a 16 cycle bit clock and 64 bits per frame
	// Frame clock is low for the left half
	task automatic run_codec(input logic pause);
		int b;
		int frame;
		int pos;
		int taken;
		logic [31:0] slot;
		logic started, clean;
		b = 0;
		frame = 0;
		taken = 0;
		slot = '0;
		started = 1'b0;
		clean = 1'b0;
		while (expected.size() == 0 ? frame < 2 : taken < expected.size()) begin
			for (int p = 0; p < 16; p++) begin
				@(negedge clk50);
				if (p == 0) begin
					i2s_sclk = 1'b0;
					i2s_lrclk = (b >= 32);	// Frame clock moves with the fall
				end
				// Enable drops at left bit 24 of frame 1 and returns there in frame 4
				if (pause && b == 24 && p == 6 && (frame == 1 || frame == 4))
					i2s_enable = (frame == 4);
				if (p == 8) begin
					// First rise after a frame edge carries bit 31 of the old slot
					pos = (b == 0) ? 31 : ((b <= 32) ? b - 1 : b - 33);
					if (pos == 0) begin
						started = i2s_enable;	// Slot takes a sample only if enabled here
						clean = 1'b1;
					end
					slot = {slot[30:0], i2s_din};
					clean = clean & i2s_enable;
					if (!i2s_enable || expected.size() == 0)
						check_value("i2s_din", 32'(i2s_din), 32'h0);
					if (pos == 31 && started) begin
						if (clean)
							check_value("i2s slot", slot, expected[taken]);
						taken++;
					end
					i2s_sclk = 1'b1;
				end
			end
			b = (b + 1) % 64;
			if (b == 0)
				frame++;
		end
	endtask

	// Read order and the run limit
	always @(posedge clk50) begin
		cycles++;
		if (cycles > CYCLE_LIMIT)
			fail_run($sformatf("Timeout, run still busy after %0d clk50 cycles", cycles));
		if (!reset && mem_read && mem_ack) begin
			check_value("mem_addr", 32'(mem_addr), 32'(next_addr));
			next_addr++;
		end
	end

	initial begin
		reset = 1'b1;
		i2s_enable = 1'b1;
		i2s_sclk = 1'b0;
		i2s_lrclk = 1'b1;
		tests[0] = {1'b1, 1'b0, TAG_PCM, 96'h1234_8001_7fff_fedc_0000_a55a, FMT_PCM};
		tests[1] = {1'b1, 1'b0, TAG_ALAW, 96'hd555_2aaa_80ff_7f00_13c4_e936, FMT_ALAW};
		tests[2] = {1'b1, 1'b0, TAG_MULAW, 96'hff00_7f80_0f8e_c33c_55aa_01fe, FMT_MULAW};
		tests[3] = {1'b0, 1'b0, TAG_PCM, 96'h1111_2222_3333_4444_5555_6666, FMT_UNKNOWN};
		tests[4] = {1'b1, 1'b0, 16'h0003, 96'h89ab_cdef_0123_4567_89ab_cdef, FMT_UNKNOWN};
		tests[5] = {1'b1, 1'b1, TAG_PCM, 96'h4001_c002_0ff0_f00f_7ffe_8000, FMT_PCM};
		for (int r = 0; r < ROWS; r++) begin
			@(negedge clk50);
			reset = 1'b1;
			i2s_enable = 1'b1;
			i2s_sclk = 1'b0;	// Codec idle until the header is parsed
			i2s_lrclk = 1'b1;
			next_addr = 0;
			load_image(tests[r]);
			build_expected(tests[r]);
			repeat (4) @(negedge clk50);
			reset = 1'b0;
			while (format_code == FMT_NONE)
				@(negedge clk50);
			check_value("format_code", 32'(format_code), 32'(tests[r].format));
			run_codec(tests[r].pause);
		end
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// ==== wav_player.f ====
src/audio_pkg.sv
src/wav_format_pkg.sv
src/sample_fetch.sv
src/i2s_clock_sync.sv
src/playback_control.sv
src/g711_expander.sv
src/wav_player.sv
testbench/wav_memory_model.sv
testbench/wav_player_tb.sv
